// ==== sim/event_logger_tb.sv ====
`timescale 1ns/1ps

module event_logger_tb;
    import logger_pkg::*;

    localparam int timeout_cycles = 60000;   // tests run roughly 21000 cycles

    logic              xclk;
    logic              config_rst;
    cmd_bus_t          i_cmd;
    logic [gpio_n-1:0] i_ext_di;
    log_word_t         o_log;

    integer seed   = 32'h8040_e7b8;
    int     errors = 0;
    int     checks = 0;
    int     cyc    = 0;   // model cycle number advancing at negedge

    // model copy of the configuration and inputs
    logic [1:0]        m_pps_slot = 2'd0;
    logic              m_pps_inv  = 1'b0;
    logic [3:0]        m_msg_sel  = msg_sel_off;
    logic              m_msg_inv  = 1'b0;
    logic              m_stop     = 1'b0;
    logic [gpio_n-1:0] gpio_q     = '0;
    logic              m_msg_lvl  = 1'b0;   // selected message level
    logic              m_pps_raw  = 1'b0;   // pps level before denoise
    logic              m_pps_lvl  = 1'b0;   // denoised pps level
    int                raw_since  = 0;
    logic [seq_w-1:0]  m_seq      = '0;

    // predicted records in arrival order
    int                q_chan [$];
    logic [gpio_n-1:0] q_gpio [$];
    int                q_cyc  [$];         // edge cycle or -1 for pps

    // monitor state
    logic [word_w-1:0] words [rec_words];
    int                wcnt      = 0;
    logic              gap_need  = 1'b0;
    logic              have_prev = 1'b0;   // previous msg record seen
    logic [ts_w-1:0]   prev_ts;
    int                prev_cyc;

    tb_clkgen u_clk (
        .o_clk (xclk)
    );

    event_logger_top uut (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_cmd      (i_cmd),
        .i_ext_di   (i_ext_di),
        .o_log      (o_log)
    );

    function automatic logic [31:0] conf_word(
        input logic pps_we, input logic [1:0] slot, input logic pinv,
        input logic msg_we, input logic [3:0] sel, input logic minv,
        input logic stop_we, input logic stop
    );
        logic [31:0] w;
        w = '0;
        w[conf_pps_lsb +: 2]  = slot;
        w[conf_pps_lsb + 2]   = pinv;
        w[conf_pps_lsb + 4]   = pps_we;    // spare bit 6 left clear
        w[conf_msg_lsb +: 4]  = sel;
        w[conf_msg_lsb + 4]   = minv;
        w[conf_msg_lsb + 5]   = msg_we;
        w[conf_stop_lsb]      = stop;
        w[conf_stop_lsb + 1]  = stop_we;
        return w;
    endfunction

    function automatic logic pps_raw();
        logic pin;
        case (m_pps_slot)
            2'd1:    pin = gpio_q[2];
            2'd2:    pin = gpio_q[4];
            default: pin = 1'b0;
        endcase
        return pin ^ m_pps_inv;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            $display("ERR %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic push_event(input int ch, input int edge_cyc);
        q_chan.push_back(ch);
        q_gpio.push_back(gpio_q);
        q_cyc.push_back(edge_cyc);
    endtask

    task automatic update_msg(input int edge_cyc);
        logic lvl;
        lvl = (m_msg_sel < gpio_n) ? (gpio_q[m_msg_sel] ^ m_msg_inv) : 1'b0;
        if (lvl && !m_msg_lvl && !m_stop) begin
            push_event(chan_msg, edge_cyc);   // rising edge with request 3 cycles later
        end
        m_msg_lvl = lvl;
    endtask

    task automatic bus_cycle(input logic is_addr, input logic [31:0] data);
        @(posedge xclk);
        i_cmd <= '{stb: 1'b1, is_addr: is_addr, data: data};
        @(posedge xclk);
        i_cmd <= '{stb: 1'b0, is_addr: 1'b0, data: 32'h0};
    endtask

    task automatic apply_cfg(input logic [31:0] w);
        if (w[conf_pps_lsb + 4]) begin
            m_pps_slot = w[conf_pps_lsb +: 2];
            m_pps_inv  = w[conf_pps_lsb + 2];
        end
        if (w[conf_msg_lsb + 5]) begin
            m_msg_sel = w[conf_msg_lsb +: 4];
            m_msg_inv = w[conf_msg_lsb + 4];
        end
        if (w[conf_stop_lsb + 1]) begin
            m_stop = w[conf_stop_lsb];
            if (m_stop) begin
                m_seq     = '0;     // counter and time held at zero
                have_prev = 1'b0;
            end
        end
        update_msg(cyc);   // new cfg acts like a pin change one cycle later
    endtask

    task automatic cfg_data(input logic [31:0] w);
        bus_cycle(1'b0, w);
        apply_cfg(w);
    endtask

    task automatic cfg_write(input int addr, input logic [31:0] w);
        bus_cycle(1'b1, 32'(addr));
        bus_cycle(1'b0, w);
        if (addr == logger_config_addr) begin
            apply_cfg(w);
        end
    endtask

    task automatic set_pins(input logic [gpio_n-1:0] v);
        @(posedge xclk);
        i_ext_di <= v;
        gpio_q = v;
        update_msg(cyc);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge xclk);
    endtask

    // low then high on the selected message input
    task automatic msg_pulse();
        logic [gpio_n-1:0] v;
        v = gpio_q;
        v[m_msg_sel] = m_msg_inv;
        set_pins(v);
        wait_cycles(20);
        v[m_msg_sel] = ~m_msg_inv;
        set_pins(v);
        wait_cycles(30);
    endtask

    task automatic check_record();
        logic [ts_w-1:0]   ts;
        int                ch;
        int                ecyc;
        logic [gpio_n-1:0] g;
        ts = {words[2], words[1]};
        checks++;
        assert (q_chan.size() > 0) else begin
            $display("unexpected record on o_log, header %h", words[0]);
            errors++;
        end
        if (q_chan.size() > 0) begin
            ch   = q_chan.pop_front();
            g    = q_gpio.pop_front();
            ecyc = q_cyc.pop_front();
            compare_value("o_log.data header channel", ch, words[0][15:12]);
            compare_value("o_log.data header sequence", m_seq, words[0][11:0]);
            compare_value("o_log.data gpio snapshot", g, words[3]);
            if (ch == chan_msg) begin
                if (have_prev) begin
                    compare_value("o_log.data timestamp delta", ecyc - prev_cyc, ts - prev_ts);
                end
                prev_ts   = ts;
                prev_cyc  = ecyc;
                have_prev = 1'b1;
            end
            m_seq = m_seq + 1'b1;
        end
    endtask

    // pps model and output monitor sampling mid-cycle
    always @(negedge xclk) begin
        cyc++;
        if (!config_rst) begin
            if (pps_raw() != m_pps_raw) begin
                m_pps_raw = pps_raw();
                raw_since = cyc;
            end
            if ((m_pps_raw != m_pps_lvl) && (cyc - raw_since >= 256)) begin
                m_pps_lvl = m_pps_raw;   // held long enough to pass the filter
                if (m_pps_lvl && !m_stop) begin
                    push_event(chan_pps, -1);
                end
            end
            if (o_log.stb === 1'b1) begin
                checks++;
                assert (!gap_need) else begin
                    $display("two records on o_log with no idle cycle between them");
                    errors++;
                end
                gap_need = 1'b0;
                words[wcnt] = o_log.data;
                wcnt++;
                if (wcnt == rec_words) begin
                    check_record();
                    wcnt     = 0;
                    gap_need = 1'b1;
                end
            end else begin
                gap_need = 1'b0;
                checks++;
                assert (wcnt == 0) else begin
                    $display("record on o_log stopped after %0d words", wcnt);
                    errors++;
                end
                wcnt = 0;
            end
        end
    end

    always @(posedge xclk) begin
        if (cyc >= timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", timeout_cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        logic [gpio_n-1:0] v;
        logic [3:0]        sel_o;
        logic              pinv;
        config_rst = 1'b1;
        i_cmd      = '0;
        i_ext_di   = '0;
        wait_cycles(2);
        config_rst <= 1'b0;

        // quiet after reset
        wait_cycles(200);

        // message group only before pps values with enable clear and a wrong address
        sel_o = 4'($unsigned($random(seed)) % gpio_n);
        cfg_write(logger_config_addr, conf_word(0, 2'd0, 0, 1, sel_o, 0, 0, 0));
        cfg_write(logger_config_addr, conf_word(0, 2'd1, 1, 0, 4'h0, 0, 0, 0));
        cfg_write(5, conf_word(1, 2'd1, 1, 1, 4'h0, 1, 1, 1));
        repeat (40) begin
            set_pins(gpio_n'($random(seed)));
            wait_cycles(20 + $unsigned($random(seed)) % 20);
        end

        // pps denoise on slot 1
        cfg_write(logger_config_addr, conf_word(0, 2'd0, 0, 1, msg_sel_off, 0, 0, 0));
        pinv = 1'($random(seed));
        cfg_write(logger_config_addr, conf_word(1, 2'd1, pinv, 0, 4'h0, 0, 0, 0));
        wait_cycles(300);
        repeat (20) begin
            v = gpio_q;
            v[2] = ~v[2];
            set_pins(v);
            wait_cycles(5 + $unsigned($random(seed)) % 145);   // short glitch
            v[2] = ~v[2];
            set_pins(v);
            wait_cycles(60);
            v = gpio_n'($random(seed));
            v[2] = ~gpio_q[2];
            set_pins(v);
            wait_cycles(300 + $unsigned($random(seed)) % 100);   // real level change
        end

        // both channels requesting on the same cycle
        repeat (8) begin
            v = gpio_n'($random(seed));
            v[2] = m_pps_inv;   // pps level low
            set_pins(v);
            wait_cycles(300);
            sel_o = 4'($unsigned($random(seed)) % 9);
            if (sel_o >= 4'd2) begin
                sel_o = sel_o + 4'd1;   // keep off the pps pin
            end
            cfg_write(logger_config_addr, conf_word(0, 2'd0, 0, 1, sel_o, gpio_q[sel_o], 0, 0));
            wait_cycles(20);
            v = gpio_q;
            v[2] = ~v[2];
            set_pins(v);
            wait_cycles(255);
            // invert flip lands with the pps request 260 cycles after the pin
            cfg_data(conf_word(0, 2'd0, 0, 1, sel_o, ~gpio_q[sel_o], 0, 0));
            wait_cycles(300);
        end

        // log stop
        cfg_write(logger_config_addr, conf_word(0, 2'd0, 0, 0, 4'h0, 0, 1, 1));
        wait_cycles(10);
        repeat (3) begin
            msg_pulse();
            v = gpio_q;
            v[2] = ~v[2];
            set_pins(v);
            wait_cycles(300);
        end
        cfg_write(logger_config_addr, conf_word(0, 2'd0, 0, 0, 4'h0, 0, 1, 0));
        wait_cycles(20);
        msg_pulse();   // sequence restarts at 0
        repeat (2) begin
            v = gpio_q;
            v[2] = ~v[2];
            set_pins(v);
            wait_cycles(300);
        end
        wait_cycles(400);

        checks++;
        assert (q_chan.size() == 0) else begin
            $display("%0d expected records never appeared on o_log", q_chan.size());
            errors++;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk
);

    localparam realtime half_period = 4ns;   // 8 ns clock

    initial begin
        o_clk = 1'b0;
    end

    always #(half_period) o_clk = ~o_clk;

endmodule

// ==== source/event_logger_top.sv ====
`timescale 1ns/1ps

module event_logger_top (
    input  logic                          xclk,
    input  logic                          config_rst,
    input  logger_pkg::cmd_bus_t          i_cmd,
    input  logic [logger_pkg::gpio_n-1:0] i_ext_di,
    output logger_pkg::log_word_t         o_log
);
    import logger_pkg::*;

    logger_cfg_t                cfg;
    logic                       stop;       // log_stop level
    logic [n_chan-1:0]          req;        // single-cycle event requests
    logic [n_chan-1:0]          pending;
    logic [n_chan-1:0]          ack;
    ts_slot_t [n_chan-1:0]      slot;
    logic                       word_go;
    logic [1:0]                 word_sel;
    logic                       chan;

    logger_ctrl u_ctrl (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_cmd      (i_cmd),
        .i_pending  (pending),
        .o_cfg      (cfg),
        .o_stop     (stop),
        .o_ack      (ack),
        .o_word_go  (word_go),
        .o_word_sel (word_sel),
        .o_chan     (chan)
    );

    pps_filter u_pps (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_cfg      (cfg),
        .i_ext_di   (i_ext_di),
        .o_req      (req[chan_pps])
    );

    msg_trigger u_msg (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_cfg      (cfg),
        .i_ext_di   (i_ext_di),
        .o_req      (req[chan_msg])
    );

    ts_capture u_ts (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_stop     (stop),
        .i_req      (req),
        .i_ext_di   (i_ext_di),
        .i_ack      (ack),
        .o_pending  (pending),
        .o_slot     (slot)
    );

    record_out u_rec (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_stop     (stop),
        .i_word_go  (word_go),
        .i_word_sel (word_sel),
        .i_chan     (chan),
        .i_slot     (slot),
        .o_log      (o_log)
    );

endmodule

// ==== source/logger_ctrl.sv ====
`timescale 1ns/1ps

module logger_ctrl (
    input  logic                          xclk,
    input  logic                          config_rst,
    input  logger_pkg::cmd_bus_t          i_cmd,
    input  logic [logger_pkg::n_chan-1:0] i_pending,
    output logger_pkg::logger_cfg_t       o_cfg,
    output logic                          o_stop,
    output logic [logger_pkg::n_chan-1:0] o_ack,
    output logic                          o_word_go,
    output logic [1:0]                    o_word_sel,
    output logic                          o_chan
);
    import logger_pkg::*;

    config_word_u           cmd_w;       // bus data decoded two ways
    logic [ctrl_addr_w-1:0] ctrl_addr;   // no auto-increment
    logger_cfg_t            cfg_r;
    logic                   run_r;       // record words being issued
    logic                   done_r;      // last word on output during the ack cycle
    logic [1:0]             word_cnt;
    logic                   chan_r;      // channel of current record

    assign cmd_w = i_cmd.data;

    // command decode and config register
    always_ff @(posedge xclk) begin
        if (config_rst) begin
            ctrl_addr <= '0;
            cfg_r     <= cfg_reset_val;
        end else if (i_cmd.stb) begin
            if (i_cmd.is_addr) begin
                ctrl_addr <= cmd_w.raw[ctrl_addr_w-1:0];
            end else if (ctrl_addr == ctrl_addr_w'(logger_config_addr)) begin
                if (cmd_w.conf.pps_we) begin   // pps group
                    cfg_r.pps_slot   <= cmd_w.conf.pps_slot;
                    cfg_r.pps_invert <= cmd_w.conf.pps_invert;
                    cfg_r.spare      <= cmd_w.conf.pps_spare;
                end
                if (cmd_w.conf.msg_we) begin   // message group
                    cfg_r.msg_sel    <= cmd_w.conf.msg_sel;
                    cfg_r.msg_invert <= cmd_w.conf.msg_invert;
                end
                if (cmd_w.conf.stop_we) begin
                    cfg_r.log_stop   <= cmd_w.conf.log_stop;
                end
            end
        end
    end

    assign o_cfg  = cfg_r;
    assign o_stop = cfg_r.log_stop;   // one level to capture and output

    // arbiter steps idle -> run (4 words) -> done (ack) -> idle
    always_ff @(posedge xclk) begin
        if (config_rst) begin
            run_r    <= 1'b0;
            done_r   <= 1'b0;
            word_cnt <= '0;
            chan_r   <= 1'b0;
        end else if (run_r) begin
            word_cnt <= word_cnt + 2'd1;
            if (word_cnt == 2'(rec_words - 1)) begin
                run_r  <= 1'b0;
                done_r <= 1'b1;
            end
        end else if (done_r) begin
            done_r <= 1'b0;   // pending is clear by the next idle cycle
        end else if ((|i_pending) && !cfg_r.log_stop) begin
            run_r    <= 1'b1;
            word_cnt <= '0;
            // lowest channel wins
            chan_r   <= i_pending[chan_pps] ? 1'(chan_pps) : 1'(chan_msg);
        end
    end

    always_comb begin
        o_ack = '0;
        if (done_r) begin
            o_ack[chan_r] = 1'b1;   // word 3 is on o_log now
        end
    end

    assign o_word_go  = run_r;
    assign o_word_sel = word_cnt;
    assign o_chan     = chan_r;

endmodule

// ==== source/logger_pkg.sv ====
package logger_pkg;

    localparam int gpio_n      = 10;   // number of gpio inputs
    localparam int ts_w        = 32;   // timestamp counter width
    localparam int word_w      = 16;   // log output word width
    localparam int seq_w       = 12;   // record sequence count width
    localparam int ctrl_addr_w = 7;    // command address register width

    localparam int logger_config_addr = 3;   // only writable register

    localparam int conf_pps_lsb  = 3;    // pps group 6:3 with enable 7
    localparam int conf_msg_lsb  = 8;    // msg group 12:8 with enable 13
    localparam int conf_stop_lsb = 19;   // log_stop 19 with enable 20

    localparam logic [3:0] msg_sel_off = 4'hf;   // message source disabled
    localparam logic [7:0] denoise_len = 8'd255; // denoise counter reload

    localparam int chan_pps  = 0;   // header code and arbiter priority
    localparam int chan_msg  = 1;
    localparam int n_chan    = 2;
    localparam int rec_words = 4;   // words per record

    // byte port already reassembled into one strobe per 32-bit word
    typedef struct packed {
        logic        stb;
        logic        is_addr;   // data[6:0] is the new register address
        logic [31:0] data;
    } cmd_bus_t;

    typedef struct packed {
        logic [1:0] pps_slot;    // 1 -> gpio[2], 2 -> gpio[4], else none
        logic       pps_invert;
        logic [3:0] msg_sel;     // gpio index where msg_sel_off disables
        logic       msg_invert;
        logic       log_stop;
        logic       spare;       // spare bit of the pps group
    } logger_cfg_t;

    localparam logger_cfg_t cfg_reset_val = '{
        pps_slot:   2'd0,
        pps_invert: 1'b0,
        msg_sel:    msg_sel_off,
        msg_invert: 1'b0,
        log_stop:   1'b0,
        spare:      1'b0
    };

    // data word read either as raw bits (address) or as config fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [29-conf_stop_lsb:0]             pad_hi;
            logic                                  stop_we;
            logic                                  log_stop;
            logic [conf_stop_lsb-conf_msg_lsb-7:0] pad_mid;
            logic                                  msg_we;
            logic                                  msg_invert;
            logic [3:0]                            msg_sel;
            logic                                  pps_we;
            logic                                  pps_spare;
            logic                                  pps_invert;
            logic [1:0]                            pps_slot;
            logic [conf_pps_lsb-1:0]               pad_lo;
        } conf;
    } config_word_u;

    typedef struct packed {
        logic              stb;    // high only on cycles carrying a word
        logic [word_w-1:0] data;
    } log_word_t;

    typedef struct packed {
        logic [ts_w-1:0]   ts;     // cycle count at request
        logic [gpio_n-1:0] gpio;   // input snapshot at request
    } ts_slot_t;

endpackage

// ==== source/msg_trigger.sv ====
`timescale 1ns/1ps

module msg_trigger (
    input  logic                          xclk,
    input  logic                          config_rst,
    input  logger_pkg::logger_cfg_t       i_cfg,
    input  logic [logger_pkg::gpio_n-1:0] i_ext_di,
    output logic                          o_req
);
    import logger_pkg::*;

    logic       sel_ok;    // index points at a real gpio
    logic       msg_in;
    logic [1:0] sync_r;    // 2-stage synchroniser
    logic       prev_r;    // previous synchronised level

    assign sel_ok = (i_cfg.msg_sel != msg_sel_off) && (i_cfg.msg_sel < gpio_n);
    assign msg_in = sel_ok && (i_ext_di[i_cfg.msg_sel] ^ i_cfg.msg_invert);   // off -> low

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            sync_r <= '0;
            prev_r <= 1'b0;
            o_req  <= 1'b0;
        end else begin
            sync_r <= {sync_r[0], msg_in};
            prev_r <= sync_r[1];
            o_req  <= sync_r[1] && !prev_r;   // 3 cycles after the pin edge
        end
    end

endmodule

// ==== source/pps_filter.sv ====
`timescale 1ns/1ps

module pps_filter (
    input  logic                          xclk,
    input  logic                          config_rst,
    input  logger_pkg::logger_cfg_t       i_cfg,
    input  logic [logger_pkg::gpio_n-1:0] i_ext_di,
    output logic                          o_req
);
    import logger_pkg::*;

    logic       pps_in;     // selected and inverted input
    logic [2:0] sync_r;     // 3-stage synchroniser
    logic       level_r;    // denoised level
    logic [7:0] dn_cnt;     // cycles left before level follows
    logic       level_d;

    always_comb begin
        case (i_cfg.pps_slot)
            2'd1:    pps_in = i_ext_di[2];
            2'd2:    pps_in = i_ext_di[4];
            default: pps_in = 1'b0;   // slot 0/3 unused
        endcase
        pps_in = pps_in ^ i_cfg.pps_invert;
    end

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            sync_r  <= '0;
            level_r <= 1'b0;
            dn_cnt  <= denoise_len;
            level_d <= 1'b0;
            o_req   <= 1'b0;
        end else begin
            sync_r <= {sync_r[1:0], pps_in};
            if (sync_r[2] == level_r) begin
                dn_cnt <= denoise_len;     // agreement restarts the window
            end else begin
                dn_cnt <= dn_cnt - 8'd1;
            end
            if (dn_cnt == 8'd0) begin
                level_r <= sync_r[2];      // differed for 256 cycles
            end
            level_d <= level_r;
            o_req   <= level_r && !level_d;   // rising edge only
        end
    end

endmodule

// ==== source/record_out.sv ====
`timescale 1ns/1ps

module record_out (
    input  logic                                          xclk,
    input  logic                                          config_rst,
    input  logic                                          i_stop,
    input  logic                                          i_word_go,
    input  logic [1:0]                                    i_word_sel,
    input  logic                                          i_chan,
    input  logger_pkg::ts_slot_t [logger_pkg::n_chan-1:0] i_slot,
    output logger_pkg::log_word_t                         o_log
);
    import logger_pkg::*;

    logic [seq_w-1:0]  seq_cnt;   // records sent since reset/stop
    ts_slot_t          cur;       // slot of current channel
    logic [word_w-1:0] word_nx;
    logic              stb_r;
    logic [word_w-1:0] data_r;

    assign cur = i_slot[i_chan];

    always_comb begin
        case (i_word_sel)
            2'd0:    word_nx = {(word_w-seq_w)'(i_chan), seq_cnt};   // header
            2'd1:    word_nx = cur.ts[word_w-1:0];                   // ts low
            2'd2:    word_nx = cur.ts[2*word_w-1:word_w];            // ts high
            default: word_nx = word_w'(cur.gpio);                    // gpio zero-extended
        endcase
    end

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            stb_r <= 1'b0;
        end else begin
            stb_r <= i_word_go;   // word lands one cycle after go
        end
    end

    always_ff @(posedge xclk) begin
        if (i_word_go) begin
            data_r <= word_nx;
        end
    end

    always_ff @(posedge xclk) begin
        if (config_rst || i_stop) begin
            seq_cnt <= '0;
        end else if (i_word_go && (i_word_sel == 2'(rec_words - 1))) begin
            seq_cnt <= seq_cnt + 1'b1;   // after last word of a record
        end
    end

    assign o_log = '{stb: stb_r, data: data_r};

endmodule

// ==== source/ts_capture.sv ====
`timescale 1ns/1ps

module ts_capture (
    input  logic                                         xclk,
    input  logic                                         config_rst,
    input  logic                                         i_stop,
    input  logic [logger_pkg::n_chan-1:0]                i_req,
    input  logic [logger_pkg::gpio_n-1:0]                i_ext_di,
    input  logic [logger_pkg::n_chan-1:0]                i_ack,
    output logic [logger_pkg::n_chan-1:0]                o_pending,
    output logger_pkg::ts_slot_t [logger_pkg::n_chan-1:0] o_slot
);
    import logger_pkg::*;

    logic [ts_w-1:0]   ts_cnt;     // free-running cycle counter
    logic [n_chan-1:0] take;       // slot accepts a request this cycle

    always_ff @(posedge xclk) begin
        if (config_rst || i_stop) begin
            ts_cnt <= '0;   // stop holds time at zero
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    // a request into a busy slot is dropped
    assign take = i_req & ~o_pending & {n_chan{!i_stop}};

    always_ff @(posedge xclk) begin
        if (config_rst || i_stop) begin
            o_pending <= '0;
        end else begin
            for (int ch = 0; ch < n_chan; ch++) begin
                if (i_ack[ch]) begin
                    o_pending[ch] <= 1'b0;   // record fully sent
                end else if (take[ch]) begin
                    o_pending[ch] <= 1'b1;
                end
            end
        end
    end

    // slot payload written only on an accepted request
    always_ff @(posedge xclk) begin
        for (int ch = 0; ch < n_chan; ch++) begin
            if (take[ch]) begin
                o_slot[ch].ts   <= ts_cnt;
                o_slot[ch].gpio <= i_ext_di;
            end
        end
    end

endmodule

// ==== tb.f ====
source/logger_pkg.sv
source/logger_ctrl.sv
source/pps_filter.sv
source/msg_trigger.sv
source/ts_capture.sv
source/record_out.sv
source/event_logger_top.sv
sim/tb_clkgen.sv
sim/event_logger_tb.sv
